/* ppl_ctrl_pkg.sv */
// pipeline controller package: widths, event indices, FSM codes and debug entry pc
`default_nettype none

package ppl_ctrl_pkg;

    // ========================================================================
    // widths and counts
    // ========================================================================
    localparam int ADDR_W    = 64;
    // activity sources: if0, id0, ex0, mem, wb, mul, div
    localparam int ACT_SRC_N = 7;
    localparam int EVT_N     = 7;

    // ========================================================================
    // event bits, lower index is serviced first
    // ========================================================================
    localparam int EVT_IC    = 0;
    localparam int EVT_DC    = 1;
    localparam int EVT_TLB   = 2;
    localparam int EVT_DEBUG = 3;
    localparam int EVT_EXCP  = 4;
    localparam int EVT_XRET  = 5;
    // csr-requested flush, only redirects
    localparam int EVT_FLUSH = 6;

    // ========================================================================
    // sequencer states
    // ========================================================================
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_RESET = 3'd0;
    localparam logic [ST_W-1:0] ST_INIT  = 3'd1;
    localparam logic [ST_W-1:0] ST_PROC  = 3'd2;
    localparam logic [ST_W-1:0] ST_RUN   = 3'd3;
    localparam logic [ST_W-1:0] ST_PAUSE = 3'd4;
    localparam logic [ST_W-1:0] ST_MAINT = 3'd5;

    // maintenance block states
    localparam int MS_W = 2;
    localparam logic [MS_W-1:0] MS_IDLE = 2'd0;
    localparam logic [MS_W-1:0] MS_IC   = 2'd1;
    localparam logic [MS_W-1:0] MS_DC   = 2'd2;
    localparam logic [MS_W-1:0] MS_TLB  = 2'd3;

    // ========================================================================
    // debug module halt entry
    // ========================================================================
    localparam logic [ADDR_W-1:0] DM_BASE_ADDR    = 64'h0000_0000_0000_0000;
    localparam logic [ADDR_W-1:0] DM_HALT_OFFSET  = 64'h0000_0000_0000_0800;
    // fetch target on debug entry
    localparam logic [ADDR_W-1:0] DEBUG_HALT_ADDR = DM_BASE_ADDR + DM_HALT_OFFSET;

endpackage

`default_nettype wire

/* ppl_evt_if.sv */
// event interface: pending flags, clears, boot load and redirect pc to the sequencer
`default_nettype none

interface ppl_evt_if
    import ppl_ctrl_pkg::*;
();

    // waiting events, one bit per kind
    logic [EVT_N-1:0]  pend;
    // next fetch target
    logic [ADDR_W-1:0] redirect_pc;
    // one-cycle drop of the serviced bit
    logic [EVT_N-1:0]  clr;
    // one-cycle strobe, redirect_pc <= boot address
    logic              load_boot;

    // pend holds until its clr bit is seen
    modport capture (
        output pend,
        output redirect_pc,
        input  clr,
        input  load_boot
    );

    modport seq (
        input  pend,
        input  redirect_pc,
        output clr,
        output load_boot
    );

endinterface

`default_nettype wire

/* ppl_maint_if.sv */
// maintenance interface: flush start strobes and completion pulse
`default_nettype none

interface ppl_maint_if ();

    // one start at a time, next one only after done
    logic start_ic;
    logic start_dc;
    logic start_tlb;
    logic done;

    modport seq (
        output start_ic,
        output start_dc,
        output start_tlb,
        input  done
    );

    modport maint (
        input  start_ic,
        input  start_dc,
        input  start_tlb,
        output done
    );

endinterface

`default_nettype wire

/* ppl_evt_capture.sv */
// event capture: latches redirect and maintenance requests, picks redirect pc, registers kill
`default_nettype none

module ppl_evt_capture
    import ppl_ctrl_pkg::*;
(
    input  logic              clk_i,
    input  logic              ctrl_reset_i,
    input  logic [ADDR_W-1:0] boot_addr_i,
    // event inputs, single-cycle pulses
    input  logic              ex_valid_i,
    input  logic              eret_i,
    input  logic              set_debug_i,
    input  logic              csr_flush_i,
    input  logic              fencei_i,
    input  logic              fence_i,
    input  logic              sfence_i,
    // candidate fetch targets
    input  logic [ADDR_W-1:0] trap_vec_i,
    input  logic [ADDR_W-1:0] epc_i,
    input  logic [ADDR_W-1:0] wb_npc_i,
    ppl_evt_if.capture        evt,
    output logic              ppl_kill_o
);

    logic [EVT_N-1:0]  set_vec;
    logic [EVT_N-1:0]  pend_q;
    logic [ADDR_W-1:0] redir_pc_q;
    logic [ADDR_W-1:0] redir_pc_d;
    logic              npc_evt;
    logic              kill_d;

    // ========================================================================
    // pending flags
    // ========================================================================
    always_comb begin
        set_vec            = '0;
        set_vec[EVT_IC]    = fencei_i;
        set_vec[EVT_DC]    = fence_i;
        set_vec[EVT_TLB]   = sfence_i;
        set_vec[EVT_DEBUG] = set_debug_i;
        set_vec[EVT_EXCP]  = ex_valid_i;
        set_vec[EVT_XRET]  = eret_i;
        set_vec[EVT_FLUSH] = csr_flush_i;
    end

    // set beats clear in the same cycle
    always_ff @(posedge clk_i) begin
        if (ctrl_reset_i) begin
            pend_q <= '0;
        end else begin
            pend_q <= set_vec | (pend_q & ~evt.clr);
        end
    end

    assign evt.pend = pend_q;

    // ========================================================================
    // redirect pc
    // ========================================================================
    // fence family and csr flush resume at the next sequential pc
    assign npc_evt = fencei_i | fence_i | sfence_i | csr_flush_i;

    always_comb begin
        redir_pc_d = redir_pc_q;
        if (evt.load_boot) begin
            redir_pc_d = boot_addr_i;
        end else if (npc_evt) begin
            redir_pc_d = wb_npc_i;
        end else if (ex_valid_i) begin
            redir_pc_d = trap_vec_i;
        end else if (eret_i) begin
            redir_pc_d = epc_i;
        end else if (set_debug_i) begin
            redir_pc_d = DEBUG_HALT_ADDR;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_reset_i) begin
            redir_pc_q <= '0;
        end else begin
            redir_pc_q <= redir_pc_d;
        end
    end

    assign evt.redirect_pc = redir_pc_q;

    // ========================================================================
    // kill strobe
    // ========================================================================
    // any new event, or maintenance still outstanding
    assign kill_d = (|set_vec) | pend_q[EVT_IC] | pend_q[EVT_DC] | pend_q[EVT_TLB];

    always_ff @(posedge clk_i) begin
        if (ctrl_reset_i) begin
            ppl_kill_o <= 1'b0;
        end else begin
            ppl_kill_o <= kill_d;
        end
    end

    // sequencer only clears what it sees pending
    a_clr_pending: assert property (@(posedge clk_i) disable iff (ctrl_reset_i)
        (evt.clr & ~pend_q) == '0);

endmodule

`default_nettype wire

/* ppl_maint_seq.sv */
// maintenance sequencer: drives cache and tlb flush, waits for the d-cache acknowledge
`default_nettype none

module ppl_maint_seq
    import ppl_ctrl_pkg::*;
(
    input  logic         clk_i,
    input  logic         ctrl_reset_i,
    input  logic         dcache_flush_ack_i,
    ppl_maint_if.maint   mnt,
    output logic         icache_flush_o,
    output logic         dcache_flush_o,
    output logic         tlb_flush_o
);

    logic [MS_W-1:0] ms_q;
    logic [MS_W-1:0] ms_d;

    // ========================================================================
    // flush pattern per state
    // ========================================================================
    always_comb begin
        ms_d           = ms_q;
        icache_flush_o = 1'b0;
        dcache_flush_o = 1'b0;
        tlb_flush_o    = 1'b0;
        mnt.done       = 1'b0;
        case (ms_q)
            MS_IDLE: begin
                if (mnt.start_ic) begin
                    ms_d = MS_IC;
                end else if (mnt.start_dc) begin
                    ms_d = MS_DC;
                end else if (mnt.start_tlb) begin
                    ms_d = MS_TLB;
                end
            end
            MS_IC: begin
                // i-cache pulse, d-cache writeback starts alongside
                icache_flush_o = 1'b1;
                dcache_flush_o = 1'b1;
                mnt.done       = dcache_flush_ack_i;
                ms_d           = dcache_flush_ack_i ? MS_IDLE : MS_DC;
            end
            MS_DC: begin
                // hold until the cache says it is clean
                dcache_flush_o = 1'b1;
                if (dcache_flush_ack_i) begin
                    mnt.done = 1'b1;
                    ms_d     = MS_IDLE;
                end
            end
            MS_TLB: begin
                tlb_flush_o = 1'b1;
                mnt.done    = 1'b1;
                ms_d        = MS_IDLE;
            end
            default: ms_d = MS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_reset_i) begin
            ms_q <= MS_IDLE;
        end else begin
            ms_q <= ms_d;
        end
    end

    // one request at a time from the sequencer
    a_no_start_busy: assert property (@(posedge clk_i) disable iff (ctrl_reset_i)
        (ms_q != MS_IDLE) |-> !(mnt.start_ic | mnt.start_dc | mnt.start_tlb));
    a_start_onehot: assert property (@(posedge clk_i) disable iff (ctrl_reset_i)
        $onehot0({mnt.start_ic, mnt.start_dc, mnt.start_tlb}));

endmodule

`default_nettype wire

/* ppl_seq_fsm.sv */
// pipeline sequencer: boot, run, pause, event service and fetch pc set strobe
`default_nettype none

module ppl_seq_fsm
    import ppl_ctrl_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 ctrl_reset_i,
    input  logic                 halt_i,
    input  logic [ACT_SRC_N-1:0] act_i,
    ppl_evt_if.seq               evt,
    ppl_maint_if.seq             mnt,
    output logic                 fet_act_o,
    output logic                 fet_set_en_o,
    output logic [ADDR_W-1:0]    fet_set_npc_o,
    output logic                 flush_bp_o
);

    logic [ST_W-1:0] state_q;
    logic [ST_W-1:0] state_d;
    logic            ppl_idle;
    logic            set_en_d;

    // nothing in flight in any stage or unit
    assign ppl_idle = ~|act_i;

    // ========================================================================
    // next state and strobes
    // ========================================================================
    always_comb begin
        state_d       = state_q;
        fet_act_o     = 1'b0;
        flush_bp_o    = 1'b0;
        set_en_d      = 1'b0;
        evt.clr       = '0;
        evt.load_boot = 1'b0;
        mnt.start_ic  = 1'b0;
        mnt.start_dc  = 1'b0;
        mnt.start_tlb = 1'b0;
        case (state_q)
            ST_RESET: begin
                // drain, then start from a clean predictor
                if (ppl_idle) begin
                    flush_bp_o = 1'b1;
                    state_d    = ST_INIT;
                end
            end
            ST_INIT: begin
                evt.load_boot = 1'b1;
                state_d       = ST_PROC;
            end
            ST_PROC: begin
                if (!halt_i) begin
                    set_en_d = 1'b1;
                    // maintenance first, in bit order
                    if (evt.pend[EVT_IC]) begin
                        mnt.start_ic       = 1'b1;
                        evt.clr[EVT_IC]    = 1'b1;
                        state_d            = ST_MAINT;
                    end else if (evt.pend[EVT_DC]) begin
                        mnt.start_dc       = 1'b1;
                        evt.clr[EVT_DC]    = 1'b1;
                        state_d            = ST_MAINT;
                    end else if (evt.pend[EVT_TLB]) begin
                        mnt.start_tlb      = 1'b1;
                        evt.clr[EVT_TLB]   = 1'b1;
                        state_d            = ST_MAINT;
                    end else begin
                        state_d = ST_RUN;
                        // trap and return also drop predictor history
                        if (evt.pend[EVT_DEBUG]) begin
                            evt.clr[EVT_DEBUG] = 1'b1;
                        end else if (evt.pend[EVT_EXCP]) begin
                            evt.clr[EVT_EXCP]  = 1'b1;
                            flush_bp_o         = 1'b1;
                        end else if (evt.pend[EVT_XRET]) begin
                            evt.clr[EVT_XRET]  = 1'b1;
                            flush_bp_o         = 1'b1;
                        end else if (evt.pend[EVT_FLUSH]) begin
                            evt.clr[EVT_FLUSH] = 1'b1;
                        end
                    end
                end
            end
            ST_RUN: begin
                fet_act_o = 1'b1;
                if (halt_i || (|evt.pend)) begin
                    state_d = ST_PAUSE;
                end
            end
            ST_PAUSE: begin
                if (ppl_idle) begin
                    state_d = ST_PROC;
                end
            end
            ST_MAINT: begin
                // length set by the maintenance block
                if (mnt.done) begin
                    state_d = ST_PROC;
                end
            end
            default: state_d = ST_RESET;
        endcase
    end

    // ========================================================================
    // state and fetch set registers
    // ========================================================================
    always_ff @(posedge clk_i) begin
        if (ctrl_reset_i) begin
            state_q       <= ST_RESET;
            fet_set_en_o  <= 1'b0;
            fet_set_npc_o <= '0;
        end else begin
            state_q      <= state_d;
            fet_set_en_o <= set_en_d;
            // pc as it stood in the servicing cycle
            if (set_en_d) begin
                fet_set_npc_o <= evt.redirect_pc;
            end
        end
    end

    // fetch never starts without a fresh set strobe
    a_act_after_set: assert property (@(posedge clk_i) disable iff (ctrl_reset_i)
        $rose(fet_act_o) |-> fet_set_en_o && (state_q == ST_RUN));
    a_bp_vs_maint: assert property (@(posedge clk_i) disable iff (ctrl_reset_i)
        flush_bp_o |-> !(mnt.start_ic | mnt.start_dc | mnt.start_tlb));

endmodule

`default_nettype wire

/* ppl_ctrl_top.sv */
// pipeline controller top: event capture, sequencer and maintenance on plain ports
`default_nettype none

module ppl_ctrl_top
    import ppl_ctrl_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 ctrl_reset_i,
    input  logic [ADDR_W-1:0]    boot_addr_i,
    input  logic                 halt_i,
    // stage and unit activity
    input  logic [ACT_SRC_N-1:0] act_i,
    // csr events
    input  logic                 ex_valid_i,
    input  logic                 eret_i,
    input  logic                 set_debug_i,
    input  logic                 csr_flush_i,
    input  logic [ADDR_W-1:0]    trap_vec_i,
    input  logic [ADDR_W-1:0]    epc_i,
    input  logic [ADDR_W-1:0]    wb_npc_i,
    // fence family from execute
    input  logic                 fencei_i,
    input  logic                 fence_i,
    input  logic                 sfence_i,
    input  logic                 dcache_flush_ack_i,
    // fetch control
    output logic                 fet_act_o,
    output logic                 fet_set_en_o,
    output logic [ADDR_W-1:0]    fet_set_npc_o,
    output logic                 flush_bp_o,
    output logic                 ppl_kill_o,
    // memory side maintenance
    output logic                 icache_flush_o,
    output logic                 dcache_flush_o,
    output logic                 tlb_flush_o
);

    ppl_evt_if   evt ();
    ppl_maint_if mnt ();

    ppl_evt_capture u_evt_capture (
        .clk_i        (clk_i),
        .ctrl_reset_i (ctrl_reset_i),
        .boot_addr_i  (boot_addr_i),
        .ex_valid_i   (ex_valid_i),
        .eret_i       (eret_i),
        .set_debug_i  (set_debug_i),
        .csr_flush_i  (csr_flush_i),
        .fencei_i     (fencei_i),
        .fence_i      (fence_i),
        .sfence_i     (sfence_i),
        .trap_vec_i   (trap_vec_i),
        .epc_i        (epc_i),
        .wb_npc_i     (wb_npc_i),
        .evt          (evt.capture),
        .ppl_kill_o   (ppl_kill_o)
    );

    ppl_seq_fsm u_seq_fsm (
        .clk_i         (clk_i),
        .ctrl_reset_i  (ctrl_reset_i),
        .halt_i        (halt_i),
        .act_i         (act_i),
        .evt           (evt.seq),
        .mnt           (mnt.seq),
        .fet_act_o     (fet_act_o),
        .fet_set_en_o  (fet_set_en_o),
        .fet_set_npc_o (fet_set_npc_o),
        .flush_bp_o    (flush_bp_o)
    );

    ppl_maint_seq u_maint_seq (
        .clk_i              (clk_i),
        .ctrl_reset_i       (ctrl_reset_i),
        .dcache_flush_ack_i (dcache_flush_ack_i),
        .mnt                (mnt.maint),
        .icache_flush_o     (icache_flush_o),
        .dcache_flush_o     (dcache_flush_o),
        .tlb_flush_o        (tlb_flush_o)
    );

endmodule

`default_nettype wire

/* tb_ppl_ctrl.sv */
// pipeline controller testbench: boot, traps, debug entry, fences, halt and csr flush
`default_nettype none

module tb_ppl_ctrl
    import ppl_ctrl_pkg::*;
();

    // ========================================================================
    // run limits
    // ========================================================================
    localparam int CLK_HALF     = 50;
    localparam int RESET_CYC    = 8;
    localparam int TEST_N       = 6;
    localparam int TEST_CYC_MAX = 200;
    // every test at its longest, twice over, plus reset and slack
    localparam int CYCLE_LIMIT  = 2 * TEST_N * TEST_CYC_MAX + 600;

    logic                 clk_i = 1'b0;
    logic                 ctrl_reset_i;
    logic [ADDR_W-1:0]    boot_addr_i;
    logic                 halt_i;
    logic [ACT_SRC_N-1:0] act_i = '0;
    logic                 ex_valid_i;
    logic                 eret_i;
    logic                 set_debug_i;
    logic                 csr_flush_i;
    logic [ADDR_W-1:0]    trap_vec_i;
    logic [ADDR_W-1:0]    epc_i;
    logic [ADDR_W-1:0]    wb_npc_i;
    logic                 fencei_i;
    logic                 fence_i;
    logic                 sfence_i;
    logic                 dcache_flush_ack_i = 1'b0;
    logic                 fet_act_o;
    logic                 fet_set_en_o;
    logic [ADDR_W-1:0]    fet_set_npc_o;
    logic                 flush_bp_o;
    logic                 ppl_kill_o;
    logic                 icache_flush_o;
    logic                 dcache_flush_o;
    logic                 tlb_flush_o;

    // event pulses, indexed like the pending vector
    logic [EVT_N-1:0]  evt_drv;
    logic              ev_any;
    logic [ADDR_W-1:0] exp_npc;
    logic              exp_bp;
    logic              run_fencei;
    logic              run_fence;
    logic              run_sfence;
    logic              mreq;
    logic              boot_done;
    int                boot_bp_cnt;
    int                act_hold;
    int                ack_wait;
    // cycles seen on each flush output
    int                ic_cyc = 0;
    int                dc_cyc = 0;
    int                tlb_cyc = 0;
    int                cycle_cnt = 0;
    int                err_cnt = 0;
    int                err_mark = 0;
    int                pass_cnt = 0;
    int                fail_cnt = 0;

    assign fencei_i    = evt_drv[EVT_IC];
    assign fence_i     = evt_drv[EVT_DC];
    assign sfence_i    = evt_drv[EVT_TLB];
    assign set_debug_i = evt_drv[EVT_DEBUG];
    assign ex_valid_i  = evt_drv[EVT_EXCP];
    assign eret_i      = evt_drv[EVT_XRET];
    assign csr_flush_i = evt_drv[EVT_FLUSH];
    assign ev_any      = |evt_drv;

    always #CLK_HALF clk_i = ~clk_i;

    ppl_ctrl_top u_ppl_ctrl_top (
        .clk_i              (clk_i),
        .ctrl_reset_i       (ctrl_reset_i),
        .boot_addr_i        (boot_addr_i),
        .halt_i             (halt_i),
        .act_i              (act_i),
        .ex_valid_i         (ex_valid_i),
        .eret_i             (eret_i),
        .set_debug_i        (set_debug_i),
        .csr_flush_i        (csr_flush_i),
        .trap_vec_i         (trap_vec_i),
        .epc_i              (epc_i),
        .wb_npc_i           (wb_npc_i),
        .fencei_i           (fencei_i),
        .fence_i            (fence_i),
        .sfence_i           (sfence_i),
        .dcache_flush_ack_i (dcache_flush_ack_i),
        .fet_act_o          (fet_act_o),
        .fet_set_en_o       (fet_set_en_o),
        .fet_set_npc_o      (fet_set_npc_o),
        .flush_bp_o         (flush_bp_o),
        .ppl_kill_o         (ppl_kill_o),
        .icache_flush_o     (icache_flush_o),
        .dcache_flush_o     (dcache_flush_o),
        .tlb_flush_o        (tlb_flush_o)
    );

    // ========================================================================
    // pipeline, d-cache and bookkeeping models
    // ========================================================================
    // stages stay busy while fetching and 1..4 cycles after
    always @(posedge clk_i) begin
        if (ctrl_reset_i) begin
            act_i    <= '0;
            act_hold <= 0;
        end else if (fet_act_o) begin
            act_i    <= '1;
            act_hold <= $urandom_range(1, 4);
        end else if (act_hold != 0) begin
            act_i    <= '1;
            act_hold <= act_hold - 1;
        end else begin
            act_i <= '0;
        end
    end

    // one-cycle ack after a random wait
    always @(posedge clk_i) begin
        if (ctrl_reset_i || !dcache_flush_o || dcache_flush_ack_i) begin
            dcache_flush_ack_i <= 1'b0;
            ack_wait           <= $urandom_range(0, 5);
        end else if (ack_wait == 0) begin
            dcache_flush_ack_i <= 1'b1;
        end else begin
            ack_wait <= ack_wait - 1;
        end
    end

    // maintenance request outstanding until a flush output shows
    always @(posedge clk_i) begin
        if (ctrl_reset_i) begin
            mreq        <= 1'b0;
            boot_done   <= 1'b0;
            boot_bp_cnt <= 0;
        end else begin
            if (fencei_i | fence_i | sfence_i) begin
                mreq <= 1'b1;
            end else if (icache_flush_o | dcache_flush_o | tlb_flush_o) begin
                mreq <= 1'b0;
            end
            if (flush_bp_o && !boot_done) begin
                boot_bp_cnt <= boot_bp_cnt + 1;
            end
            if (fet_set_en_o) begin
                boot_done <= 1'b1;
            end
            if (icache_flush_o) begin
                ic_cyc <= ic_cyc + 1;
            end
            if (dcache_flush_o) begin
                dc_cyc <= dc_cyc + 1;
            end
            if (tlb_flush_o) begin
                tlb_cyc <= tlb_cyc + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    function automatic void log_mismatch(input string msg);
        err_cnt++;
        $display("ERR @%0t: %s", $time, msg);
    endfunction

    function automatic void log_problem(input string msg);
        err_cnt++;
        $display("problem at %0t: %s", $time, msg);
    endfunction

    function automatic logic [ADDR_W-1:0] rand_pc();
        return {$urandom(), $urandom() & 32'hffff_fffc};
    endfunction

    // ========================================================================
    // checks, sampled on the falling edge
    // ========================================================================
    a_reset_quiet: assert property (@(negedge clk_i) $past(ctrl_reset_i) |-> !fet_act_o
        && !fet_set_en_o && !ppl_kill_o && !icache_flush_o && !dcache_flush_o && !tlb_flush_o)
        else log_mismatch("outputs not quiet after reset");
    a_boot_bp: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        fet_set_en_o && !boot_done |-> boot_bp_cnt == 1)
        else log_mismatch("boot predictor flush count is not one");
    a_set_pc: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        fet_set_en_o |-> fet_set_npc_o == exp_npc)
        else log_mismatch($sformatf("set pc %h, expected %h", fet_set_npc_o, exp_npc));
    a_set_bp: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        fet_set_en_o |-> $past(flush_bp_o) == exp_bp)
        else log_mismatch("predictor flush does not match the serviced event");
    a_kill_evt: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        ev_any |=> ppl_kill_o)
        else log_mismatch("no kill after an event");
    a_kill_pend: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        mreq |-> ppl_kill_o)
        else log_mismatch("kill dropped while maintenance pending");
    a_fetch_drop: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        $past(ev_any, 2) |-> !fet_act_o)
        else log_mismatch("fetch still active after an event");
    a_halt: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        halt_i && $past(halt_i) |-> !fet_act_o && !fet_set_en_o)
        else log_mismatch("fetch activity during halt");
    // cache and tlb flush shapes
    a_ic_one: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        icache_flush_o |-> dcache_flush_o ##1 !icache_flush_o)
        else log_mismatch("icache flush not a single cycle with dcache flush");
    a_dc_hold: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        dcache_flush_o && !dcache_flush_ack_i |=> dcache_flush_o)
        else log_mismatch("dcache flush dropped before the ack");
    a_dc_release: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        dcache_flush_o && dcache_flush_ack_i |=> !dcache_flush_o)
        else log_mismatch("dcache flush held after the ack");
    a_tlb_one: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        tlb_flush_o |=> !tlb_flush_o)
        else log_mismatch("tlb flush longer than one cycle");
    a_fencei_ic: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        run_fencei && $rose(dcache_flush_o) |-> icache_flush_o)
        else log_mismatch("fence.i without icache flush");
    a_fence_dc: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        run_fence |-> !icache_flush_o && !tlb_flush_o)
        else log_mismatch("fence drove icache or tlb flush");
    a_sfence_tlb: assert property (@(negedge clk_i) disable iff (ctrl_reset_i)
        run_sfence |-> !icache_flush_o && !dcache_flush_o)
        else log_mismatch("sfence.vma drove a cache flush");

    // ========================================================================
    // stimulus
    // ========================================================================
    task automatic wait_fetch(input logic level, input int max_cyc);
        int n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (fet_act_o !== level && n < max_cyc);
        a_fetch_wait: assert (fet_act_o === level)
            else log_problem($sformatf("fetch did not reach %0d in %0d cycles", level, max_cyc));
        @(posedge clk_i);
    endtask

    // one pulse with fresh pcs, then wait until fetch resumes
    task automatic run_event(input int kind);
        logic [EVT_N-1:0]  one_evt;
        logic [ADDR_W-1:0] tv;
        logic [ADDR_W-1:0] ep;
        logic [ADDR_W-1:0] np;
        int                ic0;
        int                dc0;
        int                tlb0;
        int                ic_n;
        int                dc_n;
        int                tlb_n;
        logic              flush_ok;
        one_evt       = '0;
        one_evt[kind] = 1'b1;
        tv            = rand_pc();
        ep            = rand_pc();
        np            = rand_pc();
        case (kind)
            EVT_EXCP:  exp_npc = tv;
            EVT_XRET:  exp_npc = ep;
            EVT_DEBUG: exp_npc = DEBUG_HALT_ADDR;
            default:   exp_npc = np;
        endcase
        // only trap entry and return drop predictor history
        exp_bp = (kind == EVT_EXCP) || (kind == EVT_XRET);
        ic0  = ic_cyc;
        dc0  = dc_cyc;
        tlb0 = tlb_cyc;
        @(posedge clk_i);
        trap_vec_i <= tv;
        epc_i      <= ep;
        wb_npc_i   <= np;
        evt_drv    <= one_evt;
        @(posedge clk_i);
        evt_drv <= '0;
        wait_fetch(1'b0, 10);
        wait_fetch(1'b1, TEST_CYC_MAX);
        // flush outputs seen during this event
        ic_n  = ic_cyc - ic0;
        dc_n  = dc_cyc - dc0;
        tlb_n = tlb_cyc - tlb0;
        case (kind)
            EVT_IC:  flush_ok = (ic_n == 1) && (dc_n >= 1) && (tlb_n == 0);
            EVT_DC:  flush_ok = (ic_n == 0) && (dc_n >= 1) && (tlb_n == 0);
            EVT_TLB: flush_ok = (ic_n == 0) && (dc_n == 0) && (tlb_n == 1);
            default: flush_ok = (ic_n == 0) && (dc_n == 0) && (tlb_n == 0);
        endcase
        a_maint_flush: assert (flush_ok)
            else log_mismatch($sformatf("flush cycles ic %0d dc %0d tlb %0d for event %0d",
                                        ic_n, dc_n, tlb_n, kind));
    endtask

    task automatic begin_test();
        err_mark = err_cnt;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: FAIL with %0d errors", name, err_cnt - err_mark);
        end
    endtask

    initial begin
        logic [ADDR_W-1:0] boot_pc;
        void'($urandom(21));
        boot_pc      = rand_pc();
        exp_npc      = boot_pc;
        exp_bp       = 1'b0;
        run_fencei   = 1'b0;
        run_fence    = 1'b0;
        run_sfence   = 1'b0;
        ctrl_reset_i <= 1'b1;
        boot_addr_i  <= boot_pc;
        halt_i       <= 1'b0;
        evt_drv      <= '0;
        trap_vec_i   <= '0;
        epc_i        <= '0;
        wb_npc_i     <= '0;
        repeat (RESET_CYC) @(posedge clk_i);
        ctrl_reset_i <= 1'b0;

        begin_test();
        wait_fetch(1'b1, 50);
        end_test("boot");
        begin_test();
        run_event(EVT_EXCP);
        run_event(EVT_XRET);
        end_test("trap and return");
        begin_test();
        run_event(EVT_DEBUG);
        end_test("debug entry");
        begin_test();
        run_fencei = 1'b1;
        run_event(EVT_IC);
        run_fencei = 1'b0;
        end_test("fence.i");
        begin_test();
        run_fence = 1'b1;
        run_event(EVT_DC);
        run_fence  = 1'b0;
        run_sfence = 1'b1;
        run_event(EVT_TLB);
        run_sfence = 1'b0;
        end_test("fence and sfence.vma");

        // halt, resume at the last redirect, then a csr flush
        begin_test();
        @(posedge clk_i);
        halt_i <= 1'b1;
        wait_fetch(1'b0, 10);
        repeat (16) @(posedge clk_i);
        exp_bp = 1'b0;
        halt_i <= 1'b0;
        wait_fetch(1'b1, 20);
        run_event(EVT_FLUSH);
        end_test("halt and csr flush");

        repeat (5) @(posedge clk_i);
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ppl_ctrl.f */
ppl_ctrl_pkg.sv
ppl_evt_if.sv
ppl_maint_if.sv
ppl_evt_capture.sv
ppl_maint_seq.sv
ppl_seq_fsm.sv
ppl_ctrl_top.sv
tb_ppl_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pipeline controller testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_ppl_ctrl \
    -f ppl_ctrl.f -o tb_ppl_ctrl
./obj_dir/tb_ppl_ctrl > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
